/* design/mem_pkg.sv */
package mem_pkg;

  // Byte address width on the read port
  localparam int ADDR_W = 32;

  // Instructions held in one cache line
  localparam int LINE_WORDS = 4;

  // Full line width as returned by the memory
  localparam int LINE_W = 128;

  // Byte offset bits within one line
  localparam int OFFSET_W = 4;

  // Byte offset bits within one instruction slot
  localparam int BYTE_OFF_W = 2;

  // Slot index taken from the line offset
  localparam int SLOT_IDX_W = OFFSET_W - BYTE_OFF_W;

  // Width of one instruction slot
  localparam int SLOT_W = LINE_W / LINE_WORDS;

  // Line tag, the address without its offset bits
  localparam int TAG_W = ADDR_W - OFFSET_W;

  // Cache line seen flat by the memory, slotted by the selector
  typedef union packed {
    logic [LINE_W-1:0]                  flat;
    logic [LINE_WORDS-1:0][SLOT_W-1:0]  slot;
  } line_u;

endpackage

/* design/fetch_pkg.sv */
package fetch_pkg;

  // Program counter width
  localparam int PC_W = 32;

  // Fixed instruction width, no compressed forms
  localparam int INSTR_W = 32;

  // PC step between consecutive instructions
  localparam int INSTR_BYTES = INSTR_W / 8;

  // First fetch address after reset
  localparam logic [PC_W-1:0] BOOT_PC = 32'h0000_0100;

  // Which PC register drives the presented PC
  // PC_CURR while nothing is issued, PC_PREV while issuing
  typedef enum logic {
    PC_CURR,
    PC_PREV
  } pc_src_t;

  // Which line the instruction is picked from
  // LINE_IN is the line arriving from memory this cycle
  typedef enum logic [1:0] {
    LINE_IN,
    LINE_REG,
    LINE_BAK
  } line_src_t;

endpackage

/* design/fetch_controller.sv */
module fetch_controller (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  // Next PC is in the line register
  input  logic                  here_i,
  // Next PC is in the line arriving now
  input  logic                  will_be_here_i,
  input  logic                  issue_ready_i,
  input  logic                  read_done_i,

  // Advance the PC registers
  output logic                  fetch_ready_o,
  output logic                  read_req_o,
  output logic                  issue_valid_o,
  output fetch_pkg::pc_src_t    pc_sel_o,
  output fetch_pkg::line_src_t  line_sel_o
);

  typedef enum logic [2:0] {
    RESET,
    STARTUP,
    CACHE_REQ,
    SEL_IN_LINE,
    SEL_IN_BACKUP
  } state_t;

  state_t state_q;
  state_t state_d;

  // State register
  // Flush restarts the fetch from the redirect PC
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= RESET;
    end else if (flush_i) begin
      state_q <= STARTUP;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      RESET: begin
        state_d = STARTUP;
      end

      // First line read is sent here
      STARTUP: begin
        state_d = CACHE_REQ;
      end

      CACHE_REQ: begin
        if (read_done_i) begin
          if (!issue_ready_i) begin
            // Stalled, the new line waits in the line register
            state_d = SEL_IN_LINE;
          end else if (will_be_here_i) begin
            // Next instruction sits in the line just captured
            state_d = SEL_IN_LINE;
          end else if (here_i) begin
            // Old line moves to backup and still holds the next one
            state_d = SEL_IN_BACKUP;
          end else begin
            // Next one needs another line, read already sent
            state_d = CACHE_REQ;
          end
        end
      end

      SEL_IN_LINE: begin
        if (issue_ready_i && !here_i) begin
          state_d = CACHE_REQ;
        end
      end

      SEL_IN_BACKUP: begin
        if (issue_ready_i) begin
          if (here_i) begin
            state_d = SEL_IN_LINE;
          end else begin
            state_d = CACHE_REQ;
          end
        end
      end

      default: begin
        state_d = RESET;
      end
    endcase
  end

  // Outputs
  // Mealy on issue_ready_i and read_done_i
  always_comb begin
    fetch_ready_o = 1'b0;
    read_req_o    = 1'b0;
    issue_valid_o = 1'b0;
    pc_sel_o      = fetch_pkg::PC_PREV;
    line_sel_o    = fetch_pkg::LINE_REG;

    case (state_q)
      RESET: begin
        pc_sel_o = fetch_pkg::PC_CURR;
      end

      STARTUP: begin
        // Read the line of the start PC and step past it
        pc_sel_o      = fetch_pkg::PC_CURR;
        fetch_ready_o = 1'b1;
        read_req_o    = 1'b1;
      end

      CACHE_REQ: begin
        // Issue straight from the returning line
        line_sel_o = fetch_pkg::LINE_IN;
        if (read_done_i) begin
          issue_valid_o = 1'b1;
          if (issue_ready_i) begin
            fetch_ready_o = 1'b1;
            // Chain the next read when no stored line covers the next PC
            read_req_o    = !here_i && !will_be_here_i;
          end
        end
      end

      SEL_IN_LINE: begin
        // Moore valid while a line is held
        issue_valid_o = 1'b1;
        if (issue_ready_i) begin
          fetch_ready_o = 1'b1;
          read_req_o    = !here_i;
        end
      end

      SEL_IN_BACKUP: begin
        line_sel_o    = fetch_pkg::LINE_BAK;
        issue_valid_o = 1'b1;
        if (issue_ready_i) begin
          fetch_ready_o = 1'b1;
          read_req_o    = !here_i;
        end
      end

      default: begin
        pc_sel_o = fetch_pkg::PC_CURR;
      end
    endcase

    // Nothing leaves the stage in the flush cycle
    if (flush_i) begin
      fetch_ready_o = 1'b0;
      read_req_o    = 1'b0;
      issue_valid_o = 1'b0;
    end
  end

endmodule

/* design/pc_gen.sv */
module pc_gen (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          flush_i,
  input  logic [fetch_pkg::PC_W-1:0]    redirect_pc_i,
  input  logic                          fetch_ready_i,
  input  fetch_pkg::pc_src_t            pc_sel_i,

  // Presented PC
  output logic [fetch_pkg::PC_W-1:0]    pc_o,
  // PC following the presented one
  output logic [fetch_pkg::PC_W-1:0]    next_pc_o,
  // Line address for the next read
  output logic [mem_pkg::ADDR_W-1:0]    line_addr_o
);

  logic [fetch_pkg::PC_W-1:0] curr_pc_q;
  logic [fetch_pkg::PC_W-1:0] prev_pc_q;

  // Current and previous PC
  // Both start at the same address after reset or flush
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      curr_pc_q <= fetch_pkg::BOOT_PC;
      prev_pc_q <= fetch_pkg::BOOT_PC;
    end else if (flush_i) begin
      curr_pc_q <= redirect_pc_i;
      prev_pc_q <= redirect_pc_i;
    end else if (fetch_ready_i) begin
      prev_pc_q <= curr_pc_q;
      curr_pc_q <= curr_pc_q + fetch_pkg::PC_W'(fetch_pkg::INSTR_BYTES);
    end
  end

  // Previous PC is the one on the issue port while issuing
  assign pc_o = (pc_sel_i == fetch_pkg::PC_CURR) ? curr_pc_q : prev_pc_q;

  // Current PC is one step ahead of the presented one
  assign next_pc_o = curr_pc_q;

  // Offset bits cleared for a line-aligned read
  // At startup this is the line of the start PC itself
  assign line_addr_o = {curr_pc_q[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W],
                        {mem_pkg::OFFSET_W{1'b0}}};

endmodule

/* design/line_buffer.sv */
module line_buffer (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            read_done_i,
  input  mem_pkg::line_u                  read_line_i,
  input  fetch_pkg::line_src_t            line_sel_i,
  input  logic [fetch_pkg::PC_W-1:0]      pc_i,
  input  logic [fetch_pkg::PC_W-1:0]      next_pc_i,

  output logic [fetch_pkg::INSTR_W-1:0]   instr_o,
  // Next PC in the line register
  output logic                            here_o,
  // Next PC in the line arriving now
  output logic                            will_be_here_o
);

  mem_pkg::line_u                 line_q;
  mem_pkg::line_u                 bak_q;
  mem_pkg::line_u                 sel_line;
  logic [mem_pkg::TAG_W-1:0]      line_tag_q;
  logic                           line_vld_q;
  logic [mem_pkg::TAG_W-1:0]      pc_tag;
  logic [mem_pkg::TAG_W-1:0]      next_tag;
  logic [mem_pkg::SLOT_IDX_W-1:0] slot_idx;

  // Line address parts of both PCs
  assign pc_tag   = pc_i[fetch_pkg::PC_W-1:mem_pkg::OFFSET_W];
  assign next_tag = next_pc_i[fetch_pkg::PC_W-1:mem_pkg::OFFSET_W];

  // Word within the line
  assign slot_idx = pc_i[mem_pkg::OFFSET_W-1:mem_pkg::BYTE_OFF_W];

  // Line register holds nothing until the first line returns
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      line_vld_q <= 1'b0;
    end else if (read_done_i) begin
      line_vld_q <= 1'b1;
    end
  end

  // Returning line pushes the current one into backup
  // Returning line always belongs to the presented PC
  always_ff @(posedge clk_i) begin
    if (read_done_i) begin
      bak_q      <= line_q;
      line_q     <= read_line_i;
      line_tag_q <= pc_tag;
    end
  end

  // Stale lines after a flush still match memory
  assign here_o = line_vld_q && (line_tag_q == next_tag);

  // Incoming line carries the tag of the presented PC
  assign will_be_here_o = read_done_i && (pc_tag == next_tag);

  // Line source for the issue port
  always_comb begin
    case (line_sel_i)
      fetch_pkg::LINE_IN: begin
        sel_line.flat = read_line_i.flat;
      end
      fetch_pkg::LINE_BAK: begin
        sel_line.flat = bak_q.flat;
      end
      default: begin
        sel_line.flat = line_q.flat;
      end
    endcase
  end

  // Slot view picks one instruction
  assign instr_o = sel_line.slot[slot_idx];

endmodule

/* design/fetch_stage.sv */
module fetch_stage (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  // Flush with its restart PC
  input  logic                            flush_i,
  input  logic [fetch_pkg::PC_W-1:0]      redirect_pc_i,

  // Line read port
  output logic                            read_req_o,
  output logic [mem_pkg::ADDR_W-1:0]      read_addr_o,
  input  logic                            read_done_i,
  input  mem_pkg::line_u                  read_line_i,

  // Issue port
  output logic                            issue_valid_o,
  output logic [fetch_pkg::INSTR_W-1:0]   instr_o,
  output logic [fetch_pkg::PC_W-1:0]      pc_o,
  input  logic                            issue_ready_i
);

  logic                         fetch_ready;
  logic                         here;
  logic                         will_be_here;
  fetch_pkg::pc_src_t           pc_sel;
  fetch_pkg::line_src_t         line_sel;
  logic [fetch_pkg::PC_W-1:0]   next_pc;

  // Sequencing of reads and issue
  fetch_controller u_fetch_controller (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .here_i         (here),
    .will_be_here_i (will_be_here),
    .issue_ready_i  (issue_ready_i),
    .read_done_i    (read_done_i),
    .fetch_ready_o  (fetch_ready),
    .read_req_o     (read_req_o),
    .issue_valid_o  (issue_valid_o),
    .pc_sel_o       (pc_sel),
    .line_sel_o     (line_sel)
  );

  // PC registers, also the read address
  pc_gen u_pc_gen (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .redirect_pc_i  (redirect_pc_i),
    .fetch_ready_i  (fetch_ready),
    .pc_sel_i       (pc_sel),
    .pc_o           (pc_o),
    .next_pc_o      (next_pc),
    .line_addr_o    (read_addr_o)
  );

  // Stored lines and instruction select
  line_buffer u_line_buffer (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .read_done_i    (read_done_i),
    .read_line_i    (read_line_i),
    .line_sel_i     (line_sel),
    .pc_i           (pc_o),
    .next_pc_i      (next_pc),
    .instr_o        (instr_o),
    .here_o         (here),
    .will_be_here_o (will_be_here)
  );

endmodule

/* verification/fetch_stage_props.sv */
module fetch_stage_props (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           flush_i,
  input  logic                           read_req_i,
  input  logic [mem_pkg::ADDR_W-1:0]     read_addr_i,
  input  logic                           read_done_i,
  input  logic                           issue_valid_i,
  input  logic                           issue_ready_i,
  input  logic [fetch_pkg::INSTR_W-1:0]  instr_i,
  input  logic [fetch_pkg::PC_W-1:0]     pc_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // One read in flight, dropped by a flush
  logic outstanding_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 1'b0;
    end else if (flush_i) begin
      outstanding_q <= 1'b0;
    end else if (read_req_i) begin
      outstanding_q <= 1'b1;
    end else if (read_done_i) begin
      outstanding_q <= 1'b0;
    end
  end

  // Issue port holds under back-pressure
  stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    issue_valid_i && !issue_ready_i |=> $stable(instr_i) && $stable(pc_i))
    else $error("instruction or pc changed while the issue port was stalled");

  // Reads are always line aligned
  read_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    read_req_i |-> read_addr_i[mem_pkg::OFFSET_W-1:0] == '0)
    else $error("read address has offset bits set");

  // A read may start in the cycle the previous one completes
  single_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    read_req_i |-> !outstanding_q || read_done_i)
    else $error("read requested while another read is outstanding");

endmodule

/* verification/tb_fetch_stage.sv */
module tb_fetch_stage;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          NUM_TESTS = 7;
  localparam logic [31:0] MEM_XOR   = 32'hA5A5_0000;
  localparam logic [31:0] LINE_MASK = ~((32'd1 << mem_pkg::OFFSET_W) - 32'd1);

  // Test table, one column per array
  // Start PC goes in by flush, except on the boot row
  // Last row lands one slot before the line the previous row left behind
  string       row_name [NUM_TESTS] = '{"boot_stream", "random_ready", "stall_on_return",
                                        "redirect_last_slot", "redirect_mid_line",
                                        "last_slot_stalled", "redirect_stale_line"};
  logic [31:0] row_pc   [NUM_TESTS] = '{fetch_pkg::BOOT_PC, 32'h0000_0400, 32'h0000_1000,
                                        32'h0000_020C, 32'h0000_3008, 32'h0000_07FC,
                                        32'h0000_081C};
  bit          row_flush[NUM_TESTS] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
  int          row_count[NUM_TESTS] = '{24, 40, 32, 12, 16, 12, 10};
  // Percent of cycles with issue_ready_i high
  int          row_ready[NUM_TESTS] = '{100, 55, 45, 100, 70, 60, 100};
  // Largest read latency in cycles
  int          row_lat  [NUM_TESTS] = '{6, 6, 1, 4, 3, 5, 2};

  logic                          clk_i;
  logic                          rst_n_i;
  logic                          flush_i;
  logic [fetch_pkg::PC_W-1:0]    redirect_pc_i;
  logic                          read_req_o;
  logic [mem_pkg::ADDR_W-1:0]    read_addr_o;
  logic                          read_done_i;
  mem_pkg::line_u                read_line_i;
  logic                          issue_valid_o;
  logic [fetch_pkg::INSTR_W-1:0] instr_o;
  logic [fetch_pkg::PC_W-1:0]    pc_o;
  logic                          issue_ready_i;

  // Memory model and run state
  logic [31:0] rng_state;
  bit          mem_busy;
  int          mem_wait;
  logic [31:0] mem_addr;
  bit          requested [logic [31:0]];
  bit          first_req_seen;
  // Issue port values seen in a stalled cycle
  bit          stall_seen;
  logic [31:0] stall_pc;
  logic [31:0] stall_instr;
  string       cur_name = "reset";
  int          cur_pct;
  int          cur_lat;
  logic [31:0] taken_pc[$];
  logic [31:0] taken_instr[$];
  int          value_errors = 0;
  int          other_errors = 0;
  int          cycle_count = 0;
  int          cycle_limit = 200;

  fetch_stage u_fetch_stage (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .redirect_pc_i (redirect_pc_i),
    .read_req_o    (read_req_o),
    .read_addr_o   (read_addr_o),
    .read_done_i   (read_done_i),
    .read_line_i   (read_line_i),
    .issue_valid_o (issue_valid_o),
    .instr_o       (instr_o),
    .pc_o          (pc_o),
    .issue_ready_i (issue_ready_i)
  );

  bind fetch_stage fetch_stage_props u_fetch_stage_props (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .read_req_i    (read_req_o),
    .read_addr_i   (read_addr_o),
    .read_done_i   (read_done_i),
    .issue_valid_i (issue_valid_o),
    .issue_ready_i (issue_ready_i),
    .instr_i       (instr_o),
    .pc_i          (pc_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Word stored at a byte address
  function automatic logic [31:0] memory_word(input logic [31:0] addr);
    return addr ^ MEM_XOR;
  endfunction

  function automatic mem_pkg::line_u build_line(input logic [31:0] addr);
    mem_pkg::line_u words;
    logic [31:0]    base;
    base = addr & LINE_MASK;
    for (int i = 0; i < mem_pkg::LINE_WORDS; i++) begin
      words.slot[mem_pkg::SLOT_IDX_W'(i)] = memory_word(base + 32'(fetch_pkg::INSTR_BYTES * i));
    end
    return words;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual == expected) else begin
      value_errors++;
      $display("ERROR %s: %s expected %h actual %h", cur_name, what, expected, actual);
    end
  endtask

  task automatic report_counts();
    $display("errors: %0d value, %0d protocol, %0d total",
             value_errors, other_errors, value_errors + other_errors);
  endtask

  // Nothing leaves the stage in reset or in RESET
  task automatic check_quiet();
    check_value("read_req_o", 32'd0, 32'(read_req_o));
    check_value("issue_valid_o", 32'd0, 32'(issue_valid_o));
  endtask

  // Outputs are settled here until the next rising edge
  task automatic sample_outputs(input bit collect);
    // Stalled issue port holds what it showed last cycle
    if (stall_seen) begin
      check_value("held pc", stall_pc, pc_o);
      check_value("held instr", stall_instr, instr_o);
    end
    stall_seen  = issue_valid_o && !issue_ready_i;
    stall_pc    = pc_o;
    stall_instr = instr_o;
    if (read_req_o) begin
      assert (!mem_busy) else begin
        other_errors++;
        $display("%s: a read was requested while another read was still outstanding", cur_name);
      end
      check_value("read address offset", 32'd0, read_addr_o & ~LINE_MASK);
      if (!first_req_seen) begin
        first_req_seen = 1'b1;
        check_value("first read address", fetch_pkg::BOOT_PC & LINE_MASK, read_addr_o);
      end
      requested[read_addr_o & LINE_MASK] = 1'b1;
      rng_state = xorshift32(rng_state);
      mem_busy  = 1'b1;
      mem_wait  = 1 + int'(rng_state % 32'(cur_lat));
      mem_addr  = read_addr_o;
    end
    if (issue_valid_o && issue_ready_i) begin
      assert (requested.exists(pc_o & LINE_MASK)) else begin
        other_errors++;
        $display("%s: instruction at %h issued from a line that was never read", cur_name, pc_o);
      end
      if (collect) begin
        taken_pc.push_back(pc_o);
        taken_instr.push_back(instr_o);
      end
    end
  endtask

  // One clock cycle, inputs change on the falling edge
  task automatic run_cycle(input bit do_flush, input logic [31:0] target, input bit collect);
    @(negedge clk_i);
    flush_i     = do_flush;
    read_done_i = 1'b0;
    read_line_i = '0;
    if (do_flush) begin
      // Pending read is abandoned
      redirect_pc_i = target;
      mem_busy      = 1'b0;
      stall_seen    = 1'b0;
    end else if (mem_busy) begin
      if (mem_wait == 1) begin
        read_done_i = 1'b1;
        read_line_i = build_line(mem_addr);
        mem_busy    = 1'b0;
      end else begin
        mem_wait = mem_wait - 1;
      end
    end
    rng_state     = xorshift32(rng_state);
    issue_ready_i = int'(rng_state % 32'd100) < cur_pct;
    #1;
    sample_outputs(collect);
  endtask

  // Taken stream must be consecutive from the start PC
  task automatic compare_stream(input logic [31:0] start, input int count);
    logic [31:0] exp_pc;
    for (int i = 0; i < count; i++) begin
      exp_pc = start + 32'(fetch_pkg::INSTR_BYTES * i);
      check_value($sformatf("pc of take %0d", i), exp_pc, taken_pc[i]);
      check_value($sformatf("instr of take %0d", i), memory_word(exp_pc), taken_instr[i]);
    end
  endtask

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("simulation timed out before all instructions were taken");
      report_counts();
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    flush_i       = 1'b0;
    redirect_pc_i = '0;
    read_done_i   = 1'b0;
    read_line_i   = '0;
    issue_ready_i = 1'b0;
    rng_state     = 32'd4850;
    for (int t = 0; t < NUM_TESTS; t++) begin
      cycle_limit += row_count[t] * (row_lat[t] + 4);
    end
    // Two cycles in reset, then one cycle in RESET
    @(negedge clk_i);
    #1;
    check_quiet();
    @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    check_quiet();
    for (int t = 0; t < NUM_TESTS; t++) begin
      cur_name = row_name[t];
      cur_pct  = row_ready[t];
      cur_lat  = row_lat[t];
      taken_pc.delete();
      taken_instr.delete();
      if (row_flush[t]) begin
        run_cycle(1'b1, row_pc[t], 1'b0);
      end
      while (taken_pc.size() < row_count[t]) begin
        run_cycle(1'b0, '0, 1'b1);
      end
      compare_stream(row_pc[t], row_count[t]);
    end
    report_counts();
    if (value_errors + other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* compile.f */
design/mem_pkg.sv
design/fetch_pkg.sv
design/fetch_controller.sv
design/pc_gen.sv
design/line_buffer.sv
design/fetch_stage.sv
verification/fetch_stage_props.sv
verification/tb_fetch_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch_stage
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Build, run, and pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -qx "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
